// ==== verilog/mcr3_input_settings.svh ====
`ifndef MCR3_INPUT_SETTINGS_SVH
`define MCR3_INPUT_SETTINGS_SVH

// ====================
// Download stream
// ====================

// Index that carries the game code byte
`define MCR3_GAME_INDEX 8'd1

// Index that carries the DIP switch bytes
`define MCR3_DIP_INDEX 8'd254

// Only the first two DIP bytes are kept
`define MCR3_DIP_BYTES 2

// ====================
// Players and ports
// ====================

`define MCR3_PLAYERS 3

// Active-low port, nothing pressed
`define MCR3_PORT_IDLE 8'hff

`endif

// ==== verilog/mcr3_input_pkg.sv ====
`include "mcr3_input_settings.svh"

package mcr3_input_pkg;

	// ====================
	// Game selection
	// ====================

	// Any unknown game code decodes to GAME_NONE
	typedef enum logic [1:0] {
		GAME_RAMPAGE     = 2'd0,
		GAME_SARGE       = 2'd1,
		GAME_POWER_DRIVE = 2'd2,
		GAME_NONE        = 2'd3
	} game_t;

	// ====================
	// Player controls
	// ====================

	// Same bit order as the host joystick word, coin at bit 9
	typedef struct packed {
		logic coin;
		logic start;
		logic fire_d;
		logic fire_c;
		logic fire_b;
		logic fire_a;
		logic up;
		logic down;
		logic left;
		logic right;
	} joy_t;

	// Input port byte as the game CPU reads it, active low
	typedef logic [7:0] port_byte_t;

	// Power Drive gear, one bit per player
	typedef logic [`MCR3_PLAYERS-1:0] gear_t;

endpackage

// ==== verilog/game_config.sv ====
`timescale 1ns/1ps
`include "mcr3_input_settings.svh"

module game_config import mcr3_input_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        dl_wr,
	input  logic [7:0]  dl_index,
	input  logic [24:0] dl_addr,
	input  logic [7:0]  dl_data,
	output game_t       game,
	output port_byte_t  dip0,
	output port_byte_t  dip1
);

	logic [7:0] game_code;
	game_t      game_dec;
	logic       game_wr;
	logic       dip_wr;

	assign game_wr = dl_wr && (dl_index == `MCR3_GAME_INDEX);
	assign dip_wr  = dl_wr && (dl_index == `MCR3_DIP_INDEX) &&
		(dl_addr < 25'(`MCR3_DIP_BYTES));

	// ====================
	// Game code
	// ====================

	always_comb begin
		case (game_code)
			8'd0:    game_dec = GAME_RAMPAGE;
			8'd1:    game_dec = GAME_SARGE;
			8'd2:    game_dec = GAME_POWER_DRIVE;
			default: game_dec = GAME_NONE;
		endcase
	end

	// Raw byte first, decoded selection one cycle later
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			game_code <= 8'd0;
			game      <= GAME_RAMPAGE;
		end else begin
			if (game_wr)
				game_code <= dl_data;
			game <= game_dec;
		end
	end

	// ====================
	// DIP switches
	// ====================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dip0 <= 8'hff;
			dip1 <= 8'hff;
		end else if (dip_wr) begin
			if (dl_addr[0])
				dip1 <= dl_data;
			else
				dip0 <= dl_data;
		end
	end

	// Writes past the kept DIP bytes are dropped
	property p_dip_out_of_range;
		@(posedge clk_sys) disable iff (reset)
		(dl_wr && (dl_index == `MCR3_DIP_INDEX) && (dl_addr >= 25'(`MCR3_DIP_BYTES)))
			|=> ($stable(dip0) && $stable(dip1));
	endproperty

	a_dip_out_of_range: assert property (p_dip_out_of_range)
		else $error("DIP byte changed by a write outside the DIP range");

endmodule

// ==== verilog/gear_toggle.sv ====
`timescale 1ns/1ps

module gear_toggle import mcr3_input_pkg::*; (
	input  logic  clk_sys,
	input  logic  reset,
	input  gear_t shift,
	output gear_t gear
);

	// Shift buttons from the previous cycle
	gear_t shift_prev;
	gear_t shift_rise;

	// Only a fresh press counts, a held button does nothing
	assign shift_rise = shift & ~shift_prev;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			shift_prev <= '0;
			gear       <= '0;
		end else begin
			shift_prev <= shift;
			gear       <= gear ^ shift_rise;
		end
	end

	// ====================
	// Checks
	// ====================

	// Gear holds without a new press on any player
	property p_gear_hold;
		@(posedge clk_sys) disable iff (reset)
		(shift_rise == '0) |=> $stable(gear);
	endproperty

	a_gear_hold: assert property (p_gear_hold)
		else $error("Gear changed without a shift press");

endmodule

// ==== verilog/input_port_mux.sv ====
`timescale 1ns/1ps
`include "mcr3_input_settings.svh"

module input_port_mux import mcr3_input_pkg::*; (
	input  game_t      game,
	input  port_byte_t dip0,
	input  port_byte_t dip1,
	input  joy_t       joy1,
	input  joy_t       joy2,
	input  joy_t       joy3,
	input  logic       stick_mode,
	input  logic [1:0] snd_stat,
	input  gear_t      gear,
	output port_byte_t input0,
	output port_byte_t input1,
	output port_byte_t input2,
	output port_byte_t input3,
	output port_byte_t input4
);

	// Sarge twin stick, returns {rd, ru, ld, lu}
	function automatic logic [3:0] twin_stick(input joy_t j, input logic one_stick);
		logic lu;
		logic ld;
		logic ru;
		logic rd;
		if (one_stick) begin
			// Diagonals drive both treads
			lu = j.up | j.right;
			ld = j.down | j.left;
			ru = j.up | j.left;
			rd = j.down | j.right;
		end else begin
			// Left tread on the stick, right tread on two buttons
			lu = j.up;
			ld = j.down;
			ru = j.fire_c;
			rd = j.fire_b;
		end
		return {rd, ru, ld, lu};
	endfunction

	logic       coin_any;
	logic [3:0] sarge1;
	logic [3:0] sarge2;

	assign coin_any = joy1.coin | joy2.coin | joy3.coin;
	assign sarge1   = twin_stick(joy1, stick_mode);
	assign sarge2   = twin_stick(joy2, stick_mode);

	// ====================
	// Port builder
	// ====================

	always_comb begin
		input0 = `MCR3_PORT_IDLE;
		input1 = `MCR3_PORT_IDLE;
		input2 = `MCR3_PORT_IDLE;
		input3 = dip0;
		input4 = `MCR3_PORT_IDLE;

		case (game)
			GAME_RAMPAGE: begin
				// Any player's coin counts as coin 1
				input0 = ~{2'b00, dip1[0], 1'b0, 2'b00, 1'b0, coin_any};
				input1 = ~{2'b00, joy1.fire_b, joy1.fire_a,
					joy1.left, joy1.down, joy1.right, joy1.up};
				input2 = ~{2'b00, joy2.fire_b, joy2.fire_a,
					joy2.left, joy2.down, joy2.right, joy2.up};
				input4 = ~{snd_stat[0], 1'b0, joy3.fire_b, joy3.fire_a,
					joy3.left, joy3.down, joy3.right, joy3.up};
			end
			GAME_SARGE: begin
				input0 = ~{2'b00, dip1[0], 1'b0, joy2.start, joy1.start,
					joy2.coin, joy1.coin};
				input1 = ~{joy1.fire_d, joy1.fire_d, joy1.fire_a, joy1.fire_a, sarge1};
				input2 = ~{joy2.fire_d, joy2.fire_d, joy2.fire_a, joy2.fire_a, sarge2};
			end
			GAME_POWER_DRIVE: begin
				// Gear bit set means low gear, reads as pressed
				input0 = ~{2'b00, dip1[0], 1'b0, 1'b0, joy3.coin, joy2.coin, joy1.coin};
				input1 = ~{joy2.fire_b, joy2.fire_a, gear[1], joy2.fire_c,
					joy1.fire_b, joy1.fire_a, gear[0], joy1.fire_c};
				input2 = ~{snd_stat[0], 3'b000, joy3.fire_b, joy3.fire_a,
					gear[2], joy3.fire_c};
			end
			default: begin
				// Unknown game, only the DIP port is live
			end
		endcase
	end

endmodule

// ==== verilog/mcr3_input_top.sv ====
`timescale 1ns/1ps

module mcr3_input_top import mcr3_input_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        dl_wr,
	input  logic [7:0]  dl_index,
	input  logic [24:0] dl_addr,
	input  logic [7:0]  dl_data,
	input  joy_t        joy1,
	input  joy_t        joy2,
	input  joy_t        joy3,
	input  logic        stick_mode,
	input  logic [1:0]  snd_stat,
	output port_byte_t  input0,
	output port_byte_t  input1,
	output port_byte_t  input2,
	output port_byte_t  input3,
	output port_byte_t  input4
);

	game_t      game;
	port_byte_t dip0;
	port_byte_t dip1;
	gear_t      gear;

	// ====================
	// Configuration
	// ====================

	game_config i_game_config (
		.clk_sys (clk_sys),
		.reset   (reset),
		.dl_wr   (dl_wr),
		.dl_index(dl_index),
		.dl_addr (dl_addr),
		.dl_data (dl_data),
		.game    (game),
		.dip0    (dip0),
		.dip1    (dip1)
	);

	// Fire D is the gear shift button on every player
	gear_toggle i_gear_toggle (
		.clk_sys(clk_sys),
		.reset  (reset),
		.shift  ({joy3.fire_d, joy2.fire_d, joy1.fire_d}),
		.gear   (gear)
	);

	// ====================
	// Input ports
	// ====================

	input_port_mux i_input_port_mux (
		.game      (game),
		.dip0      (dip0),
		.dip1      (dip1),
		.joy1      (joy1),
		.joy2      (joy2),
		.joy3      (joy3),
		.stick_mode(stick_mode),
		.snd_stat  (snd_stat),
		.gear      (gear),
		.input0    (input0),
		.input1    (input1),
		.input2    (input2),
		.input3    (input3),
		.input4    (input4)
	);

endmodule

// ==== dv/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
	parameter int period_ns    = 20,
	parameter int reset_cycles = 16
) (
	input  logic reset_force,
	output logic clk_sys,
	output logic reset
);

	logic por;

	initial begin
		clk_sys = 1'b0;
		forever #(period_ns / 2) clk_sys = ~clk_sys;
	end

	// Power-on reset, released on a falling edge
	initial begin
		por = 1'b1;
		repeat (reset_cycles) @(posedge clk_sys);
		@(negedge clk_sys);
		por = 1'b0;
	end

	assign reset = por | reset_force;

endmodule

// ==== dv/mcr3_input_tb.sv ====
`timescale 1ns/1ps
`include "mcr3_input_settings.svh"

module mcr3_input_tb import mcr3_input_pkg::*; ();

	localparam int period_ns    = 20;
	localparam int reset_cycles = 16;
	localparam int n_random     = 24;
	// Random loops plus the directed steps of every test
	localparam int test_cycles  = reset_cycles + 4 * n_random + 80;

	logic        clk_sys;
	logic        reset;
	logic        reset_force;
	logic        dl_wr;
	logic [7:0]  dl_index;
	logic [24:0] dl_addr;
	logic [7:0]  dl_data;
	joy_t        joy1;
	joy_t        joy2;
	joy_t        joy3;
	logic        stick_mode;
	logic [1:0]  snd_stat;
	port_byte_t  input0;
	port_byte_t  input1;
	port_byte_t  input2;
	port_byte_t  input3;
	port_byte_t  input4;

	// Reference state
	game_t      exp_game;
	port_byte_t exp_dip0;
	port_byte_t exp_dip1;
	gear_t      exp_gear;
	int         error_count;
	int         check_count;

	tb_clock #(.period_ns(period_ns), .reset_cycles(reset_cycles)) i_tb_clock (
		.reset_force(reset_force),
		.clk_sys    (clk_sys),
		.reset      (reset)
	);

	mcr3_input_top i_mcr3_input_top (
		.clk_sys(clk_sys), .reset(reset), .dl_wr(dl_wr), .dl_index(dl_index),
		.dl_addr(dl_addr), .dl_data(dl_data), .joy1(joy1), .joy2(joy2), .joy3(joy3),
		.stick_mode(stick_mode), .snd_stat(snd_stat), .input0(input0), .input1(input1),
		.input2(input2), .input3(input3), .input4(input4)
	);

	// ====================
	// Expected ports
	// ====================

	// Builds the pressed bits active high, then inverts
	function automatic port_byte_t expect_port(input int n);
		joy_t       j;
		logic       lu;
		logic       ld;
		logic       ru;
		logic       rd;
		port_byte_t p;
		p = 8'h00;
		j = (n == 1) ? joy1 : (n == 2) ? joy2 : joy3;
		if (n == 3)
			return exp_dip0;
		case (exp_game)
			GAME_RAMPAGE: begin
				if (n == 0) begin
					p[5] = exp_dip1[0];
					p[0] = joy1.coin | joy2.coin | joy3.coin;
				end else begin
					p[7] = (n == 4) & snd_stat[0];
					p[5] = j.fire_b;
					p[4] = j.fire_a;
					p[3] = j.left;
					p[2] = j.down;
					p[1] = j.right;
					p[0] = j.up;
				end
			end
			GAME_SARGE: begin
				if (n == 0) begin
					p[5] = exp_dip1[0];
					p[3] = joy2.start;
					p[2] = joy1.start;
					p[1] = joy2.coin;
					p[0] = joy1.coin;
				end else if (n != 4) begin
					lu = stick_mode ? (j.up | j.right) : j.up;
					ld = stick_mode ? (j.down | j.left) : j.down;
					ru = stick_mode ? (j.up | j.left) : j.fire_c;
					rd = stick_mode ? (j.down | j.right) : j.fire_b;
					p  = {j.fire_d, j.fire_d, j.fire_a, j.fire_a, rd, ru, ld, lu};
				end
			end
			GAME_POWER_DRIVE: begin
				if (n == 0)
					p = {2'b00, exp_dip1[0], 2'b00, joy3.coin, joy2.coin, joy1.coin};
				else if (n == 1)
					p = {joy2.fire_b, joy2.fire_a, exp_gear[1], joy2.fire_c,
						joy1.fire_b, joy1.fire_a, exp_gear[0], joy1.fire_c};
				else if (n == 2)
					p = {snd_stat[0], 3'b000, joy3.fire_b, joy3.fire_a,
						exp_gear[2], joy3.fire_c};
			end
			default: p = 8'h00;
		endcase
		return ~p;
	endfunction

	function automatic joy_t random_joy();
		logic [31:0] r;
		r = $urandom;
		return joy_t'(r[9:0]);
	endfunction

	// ====================
	// Checks and drivers
	// ====================

	task automatic check_port(input string name, input port_byte_t got, input port_byte_t exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("FAIL %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_all();
		check_port("input0", input0, expect_port(0));
		check_port("input1", input1, expect_port(1));
		check_port("input2", input2, expect_port(2));
		check_port("input3", input3, expect_port(3));
		check_port("input4", input4, expect_port(4));
	endtask

	// Called right after a falling edge, returns on one too
	task automatic write_download(input logic [7:0] index, input logic [24:0] addr,
		input logic [7:0] data);
		dl_wr    = 1'b1;
		dl_index = index;
		dl_addr  = addr;
		dl_data  = data;
		@(negedge clk_sys);
		dl_wr = 1'b0;
		if (index == `MCR3_DIP_INDEX && addr < 25'(`MCR3_DIP_BYTES)) begin
			if (addr == 25'd0)
				exp_dip0 = data;
			else
				exp_dip1 = data;
		end
		if (index == `MCR3_GAME_INDEX) begin
			// Game decode lags the code byte by one more edge
			@(negedge clk_sys);
			if (data == 8'd0)
				exp_game = GAME_RAMPAGE;
			else if (data == 8'd1)
				exp_game = GAME_SARGE;
			else if (data == 8'd2)
				exp_game = GAME_POWER_DRIVE;
			else
				exp_game = GAME_NONE;
		end
	endtask

	// Two cycles of reset, the DUT returns to its reset state
	task automatic apply_reset();
		reset_force = 1'b1;
		repeat (2) @(negedge clk_sys);
		reset_force = 1'b0;
		exp_game    = GAME_RAMPAGE;
		exp_dip0    = `MCR3_PORT_IDLE;
		exp_dip1    = `MCR3_PORT_IDLE;
		exp_gear    = '0;
	endtask

	task automatic random_sticks(input int count);
		repeat (count) begin
			joy1     = random_joy();
			joy2     = random_joy();
			joy3     = random_joy();
			snd_stat = 2'($urandom);
			@(negedge clk_sys);
			check_all();
		end
	endtask

	// Random controls with every shift button released
	task automatic random_sticks_no_shift(input int count);
		repeat (count) begin
			joy1        = random_joy();
			joy2        = random_joy();
			joy3        = random_joy();
			joy1.fire_d = 1'b0;
			joy2.fire_d = 1'b0;
			joy3.fire_d = 1'b0;
			snd_stat    = 2'($urandom);
			@(negedge clk_sys);
			check_all();
		end
	endtask

	task automatic set_fire_d(input int p, input logic v);
		case (p)
			0:       joy1.fire_d = v;
			1:       joy2.fire_d = v;
			default: joy3.fire_d = v;
		endcase
	endtask

	task automatic clear_sticks();
		joy1 = '0;
		joy2 = '0;
		joy3 = '0;
		@(negedge clk_sys);
		check_all();
	endtask

	// ====================
	// Tests
	// ====================

	task automatic test_reset_defaults();
		check_all();
		random_sticks(n_random);
		for (int p = 0; p < `MCR3_PLAYERS; p++) begin
			joy1      = '0;
			joy2      = '0;
			joy3      = '0;
			joy1.coin = (p == 0);
			joy2.coin = (p == 1);
			joy3.coin = (p == 2);
			@(negedge clk_sys);
			check_all();
		end
	endtask

	task automatic test_dip_writes();
		write_download(`MCR3_DIP_INDEX, 25'd0, 8'h5a);
		check_all();
		write_download(`MCR3_DIP_INDEX, 25'd1, 8'ha4);
		check_all();
		write_download(`MCR3_DIP_INDEX, 25'd5, 8'hff);
		check_all();
	endtask

	task automatic test_sarge();
		write_download(`MCR3_GAME_INDEX, 25'd0, 8'd1);
		check_all();
		stick_mode = 1'b0;
		random_sticks(n_random);
		stick_mode = 1'b1;
		random_sticks(n_random);
		stick_mode = 1'b0;
	endtask

	task automatic test_power_drive();
		// Start from a known gear state
		clear_sticks();
		apply_reset();
		write_download(`MCR3_GAME_INDEX, 25'd0, 8'd2);
		check_all();
		for (int p = 0; p < `MCR3_PLAYERS; p++) begin
			// Held for five edges, must flip once
			set_fire_d(p, 1'b1);
			@(negedge clk_sys);
			exp_gear[p] = ~exp_gear[p];
			check_all();
			repeat (4) begin
				@(negedge clk_sys);
				check_all();
			end
			set_fire_d(p, 1'b0);
			@(negedge clk_sys);
			check_all();
		end
		random_sticks_no_shift(8);
		apply_reset();
		check_all();
		write_download(`MCR3_GAME_INDEX, 25'd0, 8'd2);
		check_all();
	endtask

	task automatic test_unknown_game();
		write_download(`MCR3_DIP_INDEX, 25'd0, 8'h3c);
		write_download(`MCR3_GAME_INDEX, 25'd0, 8'd7);
		check_all();
		random_sticks(8);
	endtask

	// ====================
	// Run control
	// ====================

	initial begin
		#(test_cycles * period_ns + 1000);
		$display("Watchdog expired, tests did not finish within %0d cycles", test_cycles);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		void'($urandom(32'hdc9b));
		reset_force = 1'b0;
		dl_wr       = 1'b0;
		dl_index    = 8'd0;
		dl_addr     = 25'd0;
		dl_data     = 8'd0;
		joy1        = '0;
		joy2        = '0;
		joy3        = '0;
		stick_mode  = 1'b0;
		snd_stat    = 2'd0;
		exp_game    = GAME_RAMPAGE;
		exp_dip0    = `MCR3_PORT_IDLE;
		exp_dip1    = `MCR3_PORT_IDLE;
		exp_gear    = '0;
		error_count = 0;
		check_count = 0;
		@(negedge clk_sys);
		while (reset)
			@(negedge clk_sys);
		test_reset_defaults();
		test_dip_writes();
		test_sarge();
		test_power_drive();
		test_unknown_game();
		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== mcr3_input.f ====
+incdir+verilog
verilog/mcr3_input_pkg.sv
verilog/game_config.sv
verilog/gear_toggle.sv
verilog/input_port_mux.sv
verilog/mcr3_input_top.sv
dv/tb_clock.sv
dv/mcr3_input_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, the log decides the result
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f mcr3_input.f --top-module mcr3_input_tb -o sim_mcr3 &&
	./obj_dir/sim_mcr3 > sim.log 2>&1 ||
	echo "Build or simulation returned an error"
cat sim.log 2>/dev/null
grep -q ">>> PASS" sim.log 2>/dev/null && exit 0 || exit 1
